//--- src/motion_pkg.sv
package motion_pkg;

	// Width of the signed step count from the host.
	// The top bit is the sign, so the count spans -128 to 127.
	localparam int count_bits = 8;

	// Width of the pulse width field.
	// It is counted in ticks, not in clk cycles.
	localparam int width_bits = 8;

	// Phases of the pulse sequencer.
	// One step is a high phase followed by a low phase of equal length.
	typedef enum logic [1:0] {
		st_idle, // Waiting for a start, no pulse in progress.
		st_high, // Step line high for width ticks.
		st_low   // Step line low for width ticks before the next step.
	} step_state_t;

	// The magnitude of the most negative count is 128.
	// It still fits the unsigned count of count_bits.

endpackage : motion_pkg

//--- src/board_pkg.sv
package board_pkg;

	// Number of clk cycles per sequencer tick.
	localparam int tick_divide = 4;

	// Width of the counter that divides clk down to the tick.
	localparam int tick_count_bits = $clog2(tick_divide);

	// Ticks that the driver enable stays on after the last pulse.
	// This gives the motor driver time to settle on the final step.
	localparam int enable_hold_ticks = 3;

	// Width of the hold counter in driver_output.
	localparam int hold_count_bits = $clog2(enable_hold_ticks + 1);

endpackage : board_pkg

//--- src/tick_divider.sv
`timescale 1ns/1ps

// Divides clk down to a single-cycle tick strobe.
// Every timed event in the axis advances on this tick.
module tick_divider (
	input  logic clk,
	input  logic reset,
	output logic tick
);

	logic [board_pkg::tick_count_bits-1:0] div_cnt; // Position within the tick period.
	logic                                  wrap;    // Last clk of the period.

	assign wrap = (div_cnt == board_pkg::tick_count_bits'(board_pkg::tick_divide - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt <= '0; // Start the period afresh.
			tick    <= 1'b0;
		end
		else begin
			tick <= wrap; // Registered, so the first tick lands tick_divide clocks after reset.
			if (wrap) begin
				div_cnt <= '0;
			end
			else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

endmodule : tick_divider

//--- src/command_capture.sv
`timescale 1ns/1ps

// Takes one move command from the host and holds it for the sequencer.
// A trigger is only taken when the axis is idle.
module command_capture (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           trigger,
	input  logic                           finished,
	input  logic [motion_pkg::count_bits-1:0] num_steps,
	input  logic [motion_pkg::width_bits-1:0] pulse_width,
	output logic                           start,
	output logic [motion_pkg::count_bits-1:0] steps_abs,
	output logic                           direction,
	output logic [motion_pkg::width_bits-1:0] width,
	output logic                           done
);

	logic                              busy;      // High from an accepted trigger until finish.
	logic                              accept;    // Trigger taken this cycle.
	logic [motion_pkg::count_bits-1:0] magnitude; // Absolute value of the requested count.

	assign accept = trigger && !busy;

	// Two's complement negate for a negative count.
	// The most negative value maps onto itself, which reads as 128 unsigned.
	assign magnitude = num_steps[motion_pkg::count_bits-1] ? (~num_steps + 1'b1) : num_steps;

	assign done = !busy; // Done only means the pulses are over, not that the rotor has settled.

	// Control flags.
	always_ff @(posedge clk) begin
		if (reset) begin
			busy  <= 1'b0;
			start <= 1'b0;
		end
		else begin
			start <= accept; // One clk strobe on the edge after the trigger.
			if (accept) begin
				busy <= 1'b1;
			end
			else if (finished) begin
				busy <= 1'b0; // Done goes high one clk after finished.
			end
		end
	end

	// Command fields are only loaded on an accepted trigger.
	always_ff @(posedge clk) begin
		if (accept) begin
			steps_abs <= magnitude;
			direction <= num_steps[motion_pkg::count_bits-1]; // Sign bit sets the direction.
			width     <= (pulse_width == '0) ? motion_pkg::width_bits'(1) : pulse_width;
		end
	end

endmodule : command_capture

//--- src/step_sequencer_fsm.sv
`timescale 1ns/1ps

// Phase control of the pulse sequencer.
// State only moves on a tick, and a start waits for the next tick.
module step_sequencer_fsm (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    tick,
	input  logic                    start,
	input  logic                    zero_steps,
	input  logic                    phase_end,
	input  logic                    last_step,
	output motion_pkg::step_state_t state,
	output logic                    finished
);

	logic pending; // A start has come in but no tick has passed yet.
	logic go;      // The tick that begins a move.

	assign go = tick && pending && (state == motion_pkg::st_idle);

	// Finished is raised on the tick itself, either at once for an empty move
	// or when the last low phase runs out.
	always_comb begin
		finished = 1'b0;
		if (go && zero_steps) begin
			finished = 1'b1;
		end
		else if (tick && (state == motion_pkg::st_low) && phase_end && last_step) begin
			finished = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= motion_pkg::st_idle;
			pending <= 1'b0;
		end
		else begin
			if (start) begin
				pending <= 1'b1; // Hold the request until a tick arrives.
			end
			else if (tick) begin
				pending <= 1'b0;
			end

			case (state)
				motion_pkg::st_idle: begin
					if (go && !zero_steps) begin
						state <= motion_pkg::st_high; // An empty move stays in idle.
					end
				end
				motion_pkg::st_high: begin
					if (tick && phase_end) begin
						state <= motion_pkg::st_low;
					end
				end
				motion_pkg::st_low: begin
					if (tick && phase_end) begin
						state <= last_step ? motion_pkg::st_idle : motion_pkg::st_high;
					end
				end
				default: state <= motion_pkg::st_idle;
			endcase
		end
	end

endmodule : step_sequencer_fsm

//--- src/step_pulse_gen.sv
`timescale 1ns/1ps

// Produces the step level for one move.
// Counts ticks within each phase and counts whole steps, and the state machine
// decides when to change phase.
module step_pulse_gen (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              tick,
	input  logic                              start,
	input  logic [motion_pkg::count_bits-1:0] steps_abs,
	input  logic [motion_pkg::width_bits-1:0] width,
	output logic                              step_level,
	output logic                              finished
);

	motion_pkg::step_state_t           state;      // Current phase from the state machine.
	logic [motion_pkg::width_bits-1:0] phase_cnt;  // Ticks seen in the current phase, from 1.
	logic [motion_pkg::count_bits-1:0] step_cnt;   // Step in progress, from 1.
	logic                              phase_end;  // This tick is the last of the phase.
	logic                              last_step;  // The step in progress is the final one.
	logic                              zero_steps; // Nothing to do for this move.
	logic                              in_phase;   // High or low phase is running.

	step_sequencer_fsm fsm_i (
		.clk        (clk),
		.reset      (reset),
		.tick       (tick),
		.start      (start),
		.zero_steps (zero_steps),
		.phase_end  (phase_end),
		.last_step  (last_step),
		.state      (state),
		.finished   (finished)
	);

	assign in_phase   = (state != motion_pkg::st_idle);
	assign phase_end  = (phase_cnt == width);
	assign last_step  = (step_cnt == steps_abs); // Full 8-bit compare so 128 steps works.
	assign zero_steps = (steps_abs == '0);
	assign step_level = (state == motion_pkg::st_high);

	// Tick counter within a phase.
	always_ff @(posedge clk) begin
		if (reset) begin
			phase_cnt <= motion_pkg::width_bits'(1);
		end
		else if (!in_phase) begin
			phase_cnt <= motion_pkg::width_bits'(1); // Ready for the first high phase.
		end
		else if (tick) begin
			if (phase_end) begin
				phase_cnt <= motion_pkg::width_bits'(1); // Each phase lasts width ticks.
			end
			else begin
				phase_cnt <= phase_cnt + 1'b1;
			end
		end
	end

	// Step counter.
	// It advances when a low phase closes, which completes one step.
	always_ff @(posedge clk) begin
		if (reset) begin
			step_cnt <= motion_pkg::count_bits'(1);
		end
		else if (!in_phase) begin
			step_cnt <= motion_pkg::count_bits'(1);
		end
		else if (tick && phase_end && (state == motion_pkg::st_low)) begin
			step_cnt <= step_cnt + 1'b1;
		end
	end

endmodule : step_pulse_gen

//--- src/driver_output.sv
`timescale 1ns/1ps

// Registers the pins that go to the stepper driver.
// Enable stays on for a few ticks after the last pulse so the motor holds position.
module driver_output (
	input  logic clk,
	input  logic reset,
	input  logic tick,
	input  logic start,
	input  logic step_level,
	input  logic direction,
	input  logic finished,
	output logic step_out,
	output logic dir_out,
	output logic enable_out
);

	logic                                  holding;  // Hold time after a move is running.
	logic [board_pkg::hold_count_bits-1:0] hold_cnt; // Ticks counted since finished.
	logic                                  hold_end; // Last tick of the hold.

	assign hold_end = holding && tick &&
		(hold_cnt == board_pkg::hold_count_bits'(board_pkg::enable_hold_ticks - 1));

	// Step and direction pins.
	always_ff @(posedge clk) begin
		if (reset) begin
			step_out <= 1'b0;
			dir_out  <= 1'b0;
		end
		else begin
			step_out <= step_level; // One clk behind the sequencer, width is unchanged.
			if (start) begin
				dir_out <= direction; // Direction is fixed for the whole move.
			end
		end
	end

	// Enable and its hold counter.
	always_ff @(posedge clk) begin
		if (reset) begin
			enable_out <= 1'b0;
			holding    <= 1'b0;
			hold_cnt   <= '0;
		end
		else if (start) begin
			enable_out <= 1'b1; // A new move during the hold keeps enable on without a gap.
			holding    <= 1'b0;
			hold_cnt   <= '0;
		end
		else if (finished) begin
			holding  <= 1'b1;
			hold_cnt <= '0;
		end
		else if (hold_end) begin
			enable_out <= 1'b0; // About enable_hold_ticks x tick_divide clocks after finish.
			holding    <= 1'b0;
		end
		else if (holding && tick) begin
			hold_cnt <= hold_cnt + 1'b1;
		end
	end

endmodule : driver_output

//--- src/stepper_axis.sv
`timescale 1ns/1ps

// Step and direction controller for one stepper axis.
// The host loads a signed count and a pulse width and strobes trigger.
module stepper_axis (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              trigger,
	input  logic [motion_pkg::count_bits-1:0] num_steps,
	input  logic [motion_pkg::width_bits-1:0] pulse_width,
	output logic                              step_out,
	output logic                              dir_out,
	output logic                              enable_out,
	output logic                              done
);

	logic                              tick;       // Slow time base for all phases.
	logic                              start;      // Accepted command, one clk.
	logic [motion_pkg::count_bits-1:0] steps_abs;  // Step count magnitude.
	logic                              direction;  // Sign of the command.
	logic [motion_pkg::width_bits-1:0] width;      // Phase length in ticks, never zero.
	logic                              step_level; // Unregistered step line.
	logic                              finished;   // Move has ended, one clk.

	tick_divider tick_i (
		.clk   (clk),
		.reset (reset),
		.tick  (tick)
	);

	command_capture capture_i (
		.clk         (clk),
		.reset       (reset),
		.trigger     (trigger),
		.finished    (finished),
		.num_steps   (num_steps),
		.pulse_width (pulse_width),
		.start       (start),
		.steps_abs   (steps_abs),
		.direction   (direction),
		.width       (width),
		.done        (done)
	);

	step_pulse_gen pulse_i (
		.clk        (clk),
		.reset      (reset),
		.tick       (tick),
		.start      (start),
		.steps_abs  (steps_abs),
		.width      (width),
		.step_level (step_level),
		.finished   (finished)
	);

	driver_output driver_i (
		.clk        (clk),
		.reset      (reset),
		.tick       (tick),
		.start      (start),
		.step_level (step_level),
		.direction  (direction),
		.finished   (finished),
		.step_out   (step_out),
		.dir_out    (dir_out),
		.enable_out (enable_out)
	);

endmodule : stepper_axis

//--- test/tb_clock.sv
`timescale 1ns/1ps

// Clock and reset source for the testbench.
module tb_clock (
	output logic clk,
	output logic reset
);

	initial begin
		clk   = 1'b0;
		reset = 1'b1; // Held for five full clk cycles.
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0; // Released on a falling edge like every other input.
	end

	always #2 clk = ~clk; // 4 ns period.

endmodule : tb_clock

//--- test/stepper_axis_props.sv
`timescale 1ns/1ps

// Timing rules on the driver pins of stepper_axis.
module stepper_axis_props (
	input logic                              clk,
	input logic                              reset,
	input logic                              trigger,
	input logic [motion_pkg::width_bits-1:0] pulse_width,
	input logic                              step_out,
	input logic                              dir_out,
	input logic                              enable_out,
	input logic                              done
);

	int assert_fails = 0; // Number of property failures so far.
	int high_len;         // Clocks that step_out has been high.
	logic [motion_pkg::width_bits-1:0] exp_width; // Width of the accepted command, never zero.

	always_ff @(posedge clk) begin
		if (reset || !step_out) begin
			high_len <= 0;
		end
		else begin
			high_len <= high_len + 1;
		end
	end

	// A trigger is taken only while done is high, and a zero width counts as one tick.
	always_ff @(posedge clk) begin
		if (reset) begin
			exp_width <= motion_pkg::width_bits'(1);
		end
		else if (trigger && done) begin
			exp_width <= (pulse_width == '0) ? motion_pkg::width_bits'(1) : pulse_width;
		end
	end

	// A step pulse lasts width ticks of tick_divide clocks each.
	pulse_width_check: assert property (@(posedge clk) disable iff (reset)
		$fell(step_out) |-> (high_len == int'(exp_width) * board_pkg::tick_divide))
		else begin
			$error("step_out pulse length differs from width times tick_divide");
			assert_fails++;
		end

	// Direction is loaded two clocks into a move and then must hold.
	dir_hold_check: assert property (@(posedge clk) disable iff (reset)
		(!done && $past(!done) && $past(!done, 2)) |-> $stable(dir_out))
		else begin
			$error("dir_out changed while a move was running");
			assert_fails++;
		end

	enable_check: assert property (@(posedge clk) disable iff (reset)
		step_out |-> enable_out)
		else begin
			$error("step_out high while enable_out was low");
			assert_fails++;
		end

	reset_check: assert property (@(posedge clk)
		$fell(reset) |-> (done && !step_out && !enable_out))
		else begin
			$error("outputs not in their idle state after reset");
			assert_fails++;
		end

endmodule : stepper_axis_props

bind stepper_axis stepper_axis_props props_i (
	.clk         (clk),
	.reset       (reset),
	.trigger     (trigger),
	.pulse_width (pulse_width),
	.step_out    (step_out),
	.dir_out     (dir_out),
	.enable_out  (enable_out),
	.done        (done)
);

//--- test/stepper_axis_tb.sv
`timescale 1ns/1ps

module stepper_axis_tb;

	localparam int kind_plain     = 0; // One move, count and direction checked.
	localparam int kind_busy      = 1; // Second trigger sent while busy.
	localparam int kind_hold      = 2; // Enable hold time measured after the move.
	localparam int kind_retrigger = 3; // New move started inside the hold.

	logic                              clk;
	logic                              reset;
	logic                              trigger;
	logic [motion_pkg::count_bits-1:0] num_steps;
	logic [motion_pkg::width_bits-1:0] pulse_width;
	logic                              step_out;
	logic                              dir_out;
	logic                              enable_out;
	logic                              done;

	int unsigned lcg_state = 64487;
	int          pulse_count = 0;  // Rising edges of step_out in the current move.
	int          enable_gaps = 0;  // Clocks with enable_out low while watched.
	logic        gap_watch = 1'b0;
	logic        step_prev = 1'b0;
	int          test_errs = 0;
	int          pass_count = 0;
	int          fail_count = 0;
	int          budget_clocks = 0; // Expected clocks for all planned moves.
	logic        limit_ready = 1'b0;
	string       names[$];
	int          counts[$];
	int          widths[$];
	int          kinds[$];

	tb_clock clock_i (.clk(clk), .reset(reset));

	stepper_axis dut_i (
		.clk         (clk),
		.reset       (reset),
		.trigger     (trigger),
		.num_steps   (num_steps),
		.pulse_width (pulse_width),
		.step_out    (step_out),
		.dir_out     (dir_out),
		.enable_out  (enable_out),
		.done        (done)
	);

	// Samples before the DUT updates, so each edge sees settled values.
	always @(posedge clk) begin
		if (step_out && !step_prev) pulse_count++;
		step_prev = step_out;
		if (gap_watch && !enable_out) enable_gaps++;
	end

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16; // Upper bits have the longer period.
	endfunction

	function automatic int abs_int(input int n);
		return (n < 0) ? -n : n;
	endfunction

	// High and low phase per step, then the hold and some slack, in clk cycles.
	function automatic int move_budget(input int n, input int w);
		return (2 * abs_int(n) * ((w == 0) ? 1 : w) + board_pkg::enable_hold_ticks + 4)
			* board_pkg::tick_divide;
	endfunction

	task automatic plan_test(input string name, input int n, input int w, input int kind);
		names.push_back(name);
		counts.push_back(n);
		widths.push_back(w);
		kinds.push_back(kind);
		budget_clocks += move_budget(n, w) * ((kind == kind_retrigger) ? 2 : 1);
	endtask

	task automatic flag_mismatch(input string name, input string what, input int exp,
		input int act);
		$display("[FAIL] %s: %s expected %0d, actual %0d", name, what, exp, act);
		test_errs++;
	endtask

	task automatic flag_failure(input string name, input string what);
		$display("Error in %s: %s", name, what);
		test_errs++;
	endtask

	// Called just after a falling edge; trigger stays high for one clk.
	task automatic issue_trigger(input int n, input int w);
		num_steps   = motion_pkg::count_bits'(n);
		pulse_width = motion_pkg::width_bits'(w);
		trigger     = 1'b1;
		@(negedge clk);
		trigger = 1'b0;
	endtask

	task automatic wait_done();
		while (!done) @(negedge clk); // The watchdog bounds this loop.
	endtask

	task automatic run_test(input string name, input int n, input int w, input int kind);
		int expected;
		int hold_clocks;
		expected  = abs_int(n);
		test_errs = 0;
		assert (done) else flag_failure(name, "done was low before the trigger");
		pulse_count = 0; // Count from the accepted trigger only.
		issue_trigger(n, w);
		assert (!done) else flag_failure(name, "done did not fall one clk after trigger");
		if (kind == kind_busy) begin
			repeat (6) @(negedge clk);
			assert (!done) else flag_failure(name, "move ended before the second trigger");
			issue_trigger(-7, 1); // Would flip dir_out and change the count if taken.
		end
		wait_done();
		assert (pulse_count == expected)
			else flag_mismatch(name, "pulses", expected, pulse_count);
		assert (int'(dir_out) == int'(n < 0))
			else flag_mismatch(name, "dir_out", int'(n < 0), int'(dir_out));
		if (kind == kind_hold) begin
			hold_clocks = 0;
			while (enable_out && hold_clocks < 40) begin
				@(negedge clk);
				hold_clocks++;
			end
			assert (hold_clocks >= 8 && hold_clocks <= 16)
				else flag_mismatch(name, "enable hold clocks", 12, hold_clocks);
		end
		if (kind == kind_retrigger) begin
			repeat (3) @(negedge clk); // Still inside the hold here.
			enable_gaps = 0;
			gap_watch   = 1'b1;
			pulse_count = 0;
			issue_trigger(n, w);
			wait_done();
			gap_watch = 1'b0;
			assert (enable_gaps == 0)
				else flag_mismatch(name, "enable low clocks", 0, enable_gaps);
			assert (pulse_count == expected)
				else flag_mismatch(name, "pulses after retrigger", expected, pulse_count);
		end
		if (test_errs == 0) begin
			pass_count++;
			$display("[PASS] %s", name);
		end
		else begin
			fail_count++;
			$display("[DONE] %s finished with %0d failed checks", name, test_errs);
		end
	endtask

	initial begin
		int r_count;
		int r_width;
		trigger     = 1'b0;
		num_steps   = '0;
		pulse_width = '0;
		plan_test("positive_small", 5, 1, kind_plain);
		plan_test("positive_wide", 3, 3, kind_plain);
		plan_test("negative_small", -3, 2, kind_plain);
		plan_test("negative_max", -128, 1, kind_plain);
		for (int i = 0; i < 4; i++) begin
			r_count = int'(lcg_next() % 6) + 1;
			if (lcg_next() % 2 == 1) r_count = -r_count;
			r_width = int'(lcg_next() % 5) + 1;
			plan_test($sformatf("random_%0d", i), r_count, r_width, kind_plain);
		end
		plan_test("width_zero", 2, 0, kind_plain);
		plan_test("zero_count", 0, 3, kind_plain);
		plan_test("busy_ignore", 3, 2, kind_busy);
		plan_test("enable_hold", 2, 1, kind_hold);
		plan_test("hold_retrigger", 2, 1, kind_retrigger);
		limit_ready = 1'b1;
		@(negedge reset);
		@(negedge clk);
		foreach (names[i]) run_test(names[i], counts[i], widths[i], kinds[i]);
		$display("Tests passed: %0d, failed: %0d, property failures: %0d",
			pass_count, fail_count, dut_i.props_i.assert_fails);
		if (fail_count == 0 && dut_i.props_i.assert_fails == 0) begin
			$display("Simulation passed");
		end
		else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// Twice the planned move time, plus the reset cycles.
	initial begin
		wait (limit_ready);
		repeat (2 * budget_clocks + 10) @(posedge clk);
		$display("Timeout: the moves did not complete within %0d clock cycles.",
			2 * budget_clocks + 10);
		$display("Simulation failed");
		$finish;
	end

endmodule : stepper_axis_tb

//--- project.f
src/motion_pkg.sv
src/board_pkg.sv
src/tick_divider.sv
src/command_capture.sv
src/step_sequencer_fsm.sv
src/step_pulse_gen.sv
src/driver_output.sv
src/stepper_axis.sv
test/tb_clock.sv
test/stepper_axis_props.sv
test/stepper_axis_tb.sv

//--- Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = stepper_axis_tb
FILE_LIST = project.f
RUN_FLAGS = +verilator+error+limit+1000
LOG       = sim.log
OBJ_DIR   = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "Simulation passed" $(LOG)

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
